// ==== logic/vga_pkg.sv ====
/* Shared constants and types of the display controller.
   Modules import this package for video RAM sizing, drawing config and RAM requests. */
package vga_pkg;

  // Video RAM word address width, 4096 words
  localparam int VMEM_AW = 12;

  // Four 4-bit pixels in one 16-bit word
  localparam int PIX_PER_WORD = 4;

  // Raster operation against the CPU read latch
  typedef enum logic [1:0] {
    ROP_REPLACE = 2'd0,
    ROP_AND     = 2'd1,
    ROP_OR      = 2'd2,
    ROP_XOR     = 2'd3
  } raster_op_e;

  // Drawing configuration used by the CPU write path
  typedef struct packed {
    logic [15:0] bitmask;
    logic [15:0] set_reset;
    logic        enable_set_reset;
    raster_op_e  raster_op;
  } draw_cfg_t;

  // Request from the CPU side to the video RAM
  typedef struct packed {
    logic               we;
    logic [1:0]         sel;
    logic [VMEM_AW-1:0] addr;
    logic [15:0]        data;
  } mem_req_t;

endpackage

// ==== logic/vga_config_regs.sv ====
/* Configuration register file on the Wishbone bus, selected when tga is high.
   Holds start address, bitmask, set/reset and control with byte-lane writes. */
`timescale 1ns/1ns

module vga_config_regs (
  input  logic                        wb_clk_i,
  input  logic                        arst_n_i,
  input  logic [15:0]                 wb_dat_i,
  input  logic [1:0]                  wb_adr_i,
  input  logic                        wb_we_i,
  input  logic [1:0]                  wb_sel_i,
  input  logic                        wb_stb_i,
  output logic [15:0]                 wb_dat_o,
  output logic                        wb_ack_o,
  output vga_pkg::draw_cfg_t          draw_cfg_o,
  output logic [vga_pkg::VMEM_AW-1:0] start_addr_o
);
  import vga_pkg::*;

  logic [15:0] start_addr_q;
  logic [15:0] bitmask_q;
  logic [15:0] set_reset_q;
  logic        esr_q;
  raster_op_e  rop_q;
  logic        accept;
  logic        wr_en;

  // Byte-lane merge of new data into an old register value
  function automatic logic [15:0] lane_merge(input logic [15:0] old_val,
                                             input logic [15:0] new_val,
                                             input logic [1:0]  sel);
    logic [15:0] res;
    res = old_val;
    if (sel[0]) res[7:0] = new_val[7:0];
    if (sel[1]) res[15:8] = new_val[15:8];
    return res;
  endfunction

  // A strobe still high during ack is not taken again
  assign accept = wb_stb_i & ~wb_ack_o;
  assign wr_en  = accept & wb_we_i;

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o     <= 1'b0;
      start_addr_q <= '0;
      bitmask_q    <= 16'hffff;
      set_reset_q  <= '0;
      esr_q        <= 1'b0;
      rop_q        <= ROP_REPLACE;
    end else begin
      wb_ack_o <= accept;
      if (wr_en) begin
        case (wb_adr_i)
          2'd0: start_addr_q <= lane_merge(start_addr_q, wb_dat_i, wb_sel_i);
          2'd1: bitmask_q <= lane_merge(bitmask_q, wb_dat_i, wb_sel_i);
          2'd2: set_reset_q <= lane_merge(set_reset_q, wb_dat_i, wb_sel_i);
          default: begin
            // Control lives in the low byte
            if (wb_sel_i[0]) begin
              esr_q <= wb_dat_i[0];
              rop_q <= raster_op_e'(wb_dat_i[2:1]);
            end
          end
        endcase
      end
    end
  end

  // Read-back
  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      case (wb_adr_i)
        2'd0:    wb_dat_o <= start_addr_q;
        2'd1:    wb_dat_o <= bitmask_q;
        2'd2:    wb_dat_o <= set_reset_q;
        default: wb_dat_o <= {13'd0, rop_q, esr_q};
      endcase
    end
  end

  assign draw_cfg_o = '{
    bitmask:          bitmask_q,
    set_reset:        set_reset_q,
    enable_set_reset: esr_q,
    raster_op:        rop_q
  };

  assign start_addr_o = start_addr_q[VMEM_AW-1:0];

endmodule

// ==== logic/cpu_mem_iface.sv ====
/* CPU access to video memory, selected when tga is low.
   Applies latch, raster op, bitmask and set/reset, then requests the RAM via the arbiter. */
`timescale 1ns/1ns

module cpu_mem_iface (
  input  logic                        wb_clk_i,
  input  logic                        arst_n_i,
  input  logic [15:0]                 wbs_dat_i,
  input  logic [vga_pkg::VMEM_AW-1:0] wbs_adr_i,
  input  logic                        wbs_we_i,
  input  logic [1:0]                  wbs_sel_i,
  input  logic                        wbs_stb_i,
  input  vga_pkg::draw_cfg_t          draw_cfg_i,
  input  logic                        gnt_i,
  input  logic [15:0]                 rd_data_i,
  output logic [15:0]                 wbs_dat_o,
  output logic                        wbs_ack_o,
  output vga_pkg::mem_req_t           req_o,
  output logic                        req_valid_o
);
  import vga_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_RD_WAIT,
    S_ACK
  } state_e;

  state_e      state_q;
  logic [15:0] latch_q;
  logic [15:0] src;
  logic [15:0] rop_res;
  logic [15:0] wr_word;

  // Write rule: source, raster op against latch, then bitmask
  always_comb begin
    src = draw_cfg_i.enable_set_reset ? draw_cfg_i.set_reset : wbs_dat_i;
    case (draw_cfg_i.raster_op)
      ROP_AND: rop_res = src & latch_q;
      ROP_OR:  rop_res = src | latch_q;
      ROP_XOR: rop_res = src ^ latch_q;
      default: rop_res = src;
    endcase
    wr_word = (rop_res & draw_cfg_i.bitmask) | (latch_q & ~draw_cfg_i.bitmask);
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (wbs_stb_i) state_q <= S_REQ;
        end
        S_REQ: begin
          // Writes finish on grant, reads wait for RAM data
          if (gnt_i) state_q <= req_o.we ? S_ACK : S_RD_WAIT;
        end
        S_RD_WAIT: state_q <= S_ACK;
        default:   state_q <= S_IDLE;
      endcase
    end
  end

  // Read latch, loaded by every CPU read
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      latch_q <= '0;
    end else if (state_q == S_RD_WAIT) begin
      latch_q <= rd_data_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (state_q == S_IDLE && wbs_stb_i) begin
      req_o <= '{we: wbs_we_i, sel: wbs_sel_i, addr: wbs_adr_i, data: wr_word};
    end
    if (state_q == S_RD_WAIT) begin
      wbs_dat_o <= rd_data_i;
    end
  end

  assign req_valid_o = (state_q == S_REQ);
  assign wbs_ack_o   = (state_q == S_ACK);

endmodule

// ==== logic/scan_gen.sv ====
/* Display timing and pixel generation from the frame buffer.
   Prefetches one word ahead through the arbiter and shifts out four pixels per word. */
`timescale 1ns/1ns

module scan_gen #(
  parameter int H_ACTIVE = 32,
  parameter int H_FP     = 4,
  parameter int H_SYNC   = 8,
  parameter int H_BP     = 4,
  parameter int V_ACTIVE = 8,
  parameter int V_FP     = 2,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 2
) (
  input  logic                        wb_clk_i,
  input  logic                        arst_n_i,
  input  logic [vga_pkg::VMEM_AW-1:0] start_addr_i,
  input  logic                        fetch_vld_i,
  input  logic [15:0]                 fetch_data_i,
  output logic                        fetch_stb_o,
  output logic [vga_pkg::VMEM_AW-1:0] fetch_addr_o,
  output logic                        hsync_o,
  output logic                        vsync_o,
  output logic                        de_o,
  output logic [3:0]                  pix_o
);
  import vga_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int HW      = $clog2(H_TOTAL);
  localparam int VW      = $clog2(V_TOTAL);

  logic [HW-1:0]      hcnt_q;
  logic [VW-1:0]      vcnt_q;
  logic [VW-1:0]      vnext;
  logic               h_active;
  logic               v_active;
  logic               hs_on;
  logic               vs_on;
  logic               word_start;
  logic               issue_bp;
  logic               issue_line;
  logic               issue;
  logic [VMEM_AW-1:0] issue_addr;
  logic [VMEM_AW-1:0] next_addr_q;
  logic [15:0]        hold_q;
  logic [15:0]        shift_q;
  logic [3:0]         pix_next;

  assign vnext    = (vcnt_q == V_TOTAL - 1) ? '0 : vcnt_q + 1'b1;
  assign h_active = hcnt_q < H_ACTIVE;
  assign v_active = vcnt_q < V_ACTIVE;
  assign hs_on    = (hcnt_q >= H_ACTIVE + H_FP) && (hcnt_q < H_ACTIVE + H_FP + H_SYNC);
  assign vs_on    = (vcnt_q >= V_ACTIVE + V_FP) && (vcnt_q < V_ACTIVE + V_FP + V_SYNC);

  assign word_start = (hcnt_q % PIX_PER_WORD) == 0;

  // Word 0 of the next line is requested late in the back porch
  assign issue_bp = (hcnt_q == H_TOTAL - PIX_PER_WORD) && (vnext < V_ACTIVE);
  // Word w+1 is requested while word w shifts out
  assign issue_line = word_start && (hcnt_q < H_ACTIVE - PIX_PER_WORD) && v_active;
  assign issue      = issue_bp | issue_line;

  // Frame restarts at start_addr, lines follow each other in memory
  assign issue_addr = (issue_bp && vnext == '0) ? start_addr_i : next_addr_q;

  assign pix_next = word_start ? hold_q[15:12] : shift_q[15:12];

  // Starts in the last back porch line so line 0 gets its prefetch
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hcnt_q <= '0;
      vcnt_q <= VW'(V_TOTAL - 1);
    end else if (hcnt_q == H_TOTAL - 1) begin
      hcnt_q <= '0;
      vcnt_q <= vnext;
    end else begin
      hcnt_q <= hcnt_q + 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_stb_o <= 1'b0;
      de_o        <= 1'b0;
      hsync_o     <= 1'b1;
      vsync_o     <= 1'b1;
      pix_o       <= '0;
    end else begin
      fetch_stb_o <= issue;
      de_o        <= h_active & v_active;
      hsync_o     <= ~hs_on;
      vsync_o     <= ~vs_on;
      pix_o       <= (h_active & v_active) ? pix_next : '0;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (issue) begin
      fetch_addr_o <= issue_addr;
      next_addr_q  <= issue_addr + 1'b1;
    end
    if (fetch_vld_i) begin
      hold_q <= fetch_data_i;
    end
    // Most significant nibble goes out first
    shift_q <= word_start ? (hold_q << 4) : (shift_q << 4);
  end

endmodule

// ==== logic/mem_arbiter.sv ====
/* Shares the single video RAM port between scan fetches and CPU requests.
   A scan fetch always wins, the CPU request waits for its grant. */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                        wb_clk_i,
  input  logic                        arst_n_i,
  input  logic                        fetch_stb_i,
  input  logic [vga_pkg::VMEM_AW-1:0] fetch_addr_i,
  input  vga_pkg::mem_req_t           cpu_req_i,
  input  logic                        cpu_req_valid_i,
  output logic                        cpu_gnt_o,
  output logic                        fetch_vld_o,
  output logic                        ram_en_o,
  output logic                        ram_we_o,
  output logic [1:0]                  ram_be_o,
  output logic [vga_pkg::VMEM_AW-1:0] ram_addr_o,
  output logic [15:0]                 ram_wdata_o
);

  always_comb begin
    cpu_gnt_o  = 1'b0;
    ram_en_o   = 1'b0;
    ram_we_o   = 1'b0;
    ram_be_o   = cpu_req_i.sel;
    ram_addr_o = cpu_req_i.addr;
    if (fetch_stb_i) begin
      ram_en_o   = 1'b1;
      ram_addr_o = fetch_addr_i;
    end else if (cpu_req_valid_i) begin
      cpu_gnt_o = 1'b1;
      ram_en_o  = 1'b1;
      ram_we_o  = cpu_req_i.we;
    end
  end

  assign ram_wdata_o = cpu_req_i.data;

  // RAM read data is there one cycle after the fetch
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_vld_o <= 1'b0;
    end else begin
      fetch_vld_o <= fetch_stb_i;
    end
  end

endmodule

// ==== logic/video_ram.sv ====
/* On-chip video memory, 16-bit words with byte enables.
   Read data appears one cycle after an enabled access. */
`timescale 1ns/1ns

module video_ram (
  input  logic                        wb_clk_i,
  input  logic                        en_i,
  input  logic                        we_i,
  input  logic [1:0]                  be_i,
  input  logic [vga_pkg::VMEM_AW-1:0] addr_i,
  input  logic [15:0]                 wdata_i,
  output logic [15:0]                 rdata_o
);
  import vga_pkg::*;

  logic [15:0] mem [0:(1 << VMEM_AW) - 1];

  always_ff @(posedge wb_clk_i) begin
    if (en_i) begin
      if (we_i) begin
        if (be_i[0]) mem[addr_i][7:0] <= wdata_i[7:0];
        if (be_i[1]) mem[addr_i][15:8] <= wdata_i[15:8];
      end
      // Old contents on a write cycle
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// ==== logic/vga_core.sv ====
/* Top level of the display controller with one Wishbone slave port.
   tga high reaches the config registers, tga low the video memory. */
`timescale 1ns/1ns

module vga_core #(
  parameter int H_ACTIVE = 32,
  parameter int H_FP     = 4,
  parameter int H_SYNC   = 8,
  parameter int H_BP     = 4,
  parameter int V_ACTIVE = 8,
  parameter int V_FP     = 2,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 2
) (
  input  logic        wb_clk_i,
  input  logic        arst_n_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic [16:1] wb_adr_i,
  input  logic        wb_we_i,
  input  logic        wb_tga_i,
  input  logic [1:0]  wb_sel_i,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  output logic        wb_ack_o,
  output logic        vga_hsync_o,
  output logic        vga_vsync_o,
  output logic        vga_de_o,
  output logic [3:0]  vga_pix_o
);
  import vga_pkg::*;

  logic               stb;
  logic [15:0]        conf_dat;
  logic               conf_ack;
  logic [15:0]        mem_dat;
  logic               mem_ack;
  draw_cfg_t          draw_cfg;
  logic [VMEM_AW-1:0] start_addr;
  mem_req_t           cpu_req;
  logic               cpu_req_valid;
  logic               cpu_gnt;
  logic               fetch_stb;
  logic               fetch_vld;
  logic [VMEM_AW-1:0] fetch_addr;
  logic               ram_en;
  logic               ram_we;
  logic [1:0]         ram_be;
  logic [VMEM_AW-1:0] ram_addr;
  logic [15:0]        ram_wdata;
  logic [15:0]        ram_rdata;

  assign stb      = wb_stb_i & wb_cyc_i;
  assign wb_dat_o = wb_tga_i ? conf_dat : mem_dat;
  assign wb_ack_o = wb_tga_i ? conf_ack : mem_ack;

  vga_config_regs config_regs0 (
    .wb_clk_i     (wb_clk_i),
    .arst_n_i     (arst_n_i),
    .wb_dat_i     (wb_dat_i),
    .wb_adr_i     (wb_adr_i[2:1]),
    .wb_we_i      (wb_we_i),
    .wb_sel_i     (wb_sel_i),
    .wb_stb_i     (stb & wb_tga_i),
    .wb_dat_o     (conf_dat),
    .wb_ack_o     (conf_ack),
    .draw_cfg_o   (draw_cfg),
    .start_addr_o (start_addr)
  );

  cpu_mem_iface cpu_mem_iface0 (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .wbs_dat_i   (wb_dat_i),
    .wbs_adr_i   (wb_adr_i[VMEM_AW:1]),
    .wbs_we_i    (wb_we_i),
    .wbs_sel_i   (wb_sel_i),
    .wbs_stb_i   (stb & ~wb_tga_i),
    .draw_cfg_i  (draw_cfg),
    .gnt_i       (cpu_gnt),
    .rd_data_i   (ram_rdata),
    .wbs_dat_o   (mem_dat),
    .wbs_ack_o   (mem_ack),
    .req_o       (cpu_req),
    .req_valid_o (cpu_req_valid)
  );

  scan_gen #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) scan_gen0 (
    .wb_clk_i     (wb_clk_i),
    .arst_n_i     (arst_n_i),
    .start_addr_i (start_addr),
    .fetch_vld_i  (fetch_vld),
    .fetch_data_i (ram_rdata),
    .fetch_stb_o  (fetch_stb),
    .fetch_addr_o (fetch_addr),
    .hsync_o      (vga_hsync_o),
    .vsync_o      (vga_vsync_o),
    .de_o         (vga_de_o),
    .pix_o        (vga_pix_o)
  );

  mem_arbiter mem_arbiter0 (
    .wb_clk_i        (wb_clk_i),
    .arst_n_i        (arst_n_i),
    .fetch_stb_i     (fetch_stb),
    .fetch_addr_i    (fetch_addr),
    .cpu_req_i       (cpu_req),
    .cpu_req_valid_i (cpu_req_valid),
    .cpu_gnt_o       (cpu_gnt),
    .fetch_vld_o     (fetch_vld),
    .ram_en_o        (ram_en),
    .ram_we_o        (ram_we),
    .ram_be_o        (ram_be),
    .ram_addr_o      (ram_addr),
    .ram_wdata_o     (ram_wdata)
  );

  video_ram video_ram0 (
    .wb_clk_i (wb_clk_i),
    .en_i     (ram_en),
    .we_i     (ram_we),
    .be_i     (ram_be),
    .addr_i   (ram_addr),
    .wdata_i  (ram_wdata),
    .rdata_o  (ram_rdata)
  );

endmodule

// ==== testbench/tb_vga_core.sv ====
/* Testbench for the display controller. Drives the Wishbone port and checks registers,
   memory write logic and the display output against a reference model. */
`timescale 1ns/1ns

module tb_vga_core;
  import vga_pkg::*;

  localparam int H_ACTIVE = 32;
  localparam int H_FP     = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BP     = 4;
  localparam int V_ACTIVE = 8;
  localparam int V_FP     = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 2;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int WORDS_PER_LINE = H_ACTIVE / PIX_PER_WORD;
  // About 30 frames of 672 cycles covering six checked frames and the bus traffic
  localparam int MAX_CYCLES = 20000;

  logic        wb_clk_i;
  logic        arst_n_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic [16:1] wb_adr_i;
  logic        wb_we_i;
  logic        wb_tga_i;
  logic [1:0]  wb_sel_i;
  logic        wb_stb_i;
  logic        wb_cyc_i;
  logic        wb_ack_o;
  logic        vga_hsync_o;
  logic        vga_vsync_o;
  logic        vga_de_o;
  logic [3:0]  vga_pix_o;

  // Reference model state
  logic [15:0]        shadow_mem [0:(1 << VMEM_AW) - 1];
  logic [15:0]        shadow_regs [0:3];
  logic [15:0]        shadow_latch;
  logic [VMEM_AW-1:0] scratch_q [$];
  integer             seed;
  int                 data_errors;
  int                 disp_errors;
  int                 cycle_cnt;
  logic               chk_req;

  // Display monitor state
  int                 pix_k;
  int                 line_y;
  int                 hs_low;
  int                 vs_low;
  logic               frame_seen;
  logic               pix_on;
  logic               de_q;
  logic               hs_q;
  logic               vs_q;
  logic [VMEM_AW-1:0] frame_start;

  vga_core #(
    .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
    .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP)
  ) dut0 (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_adr_i    (wb_adr_i),
    .wb_we_i     (wb_we_i),
    .wb_tga_i    (wb_tga_i),
    .wb_sel_i    (wb_sel_i),
    .wb_stb_i    (wb_stb_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_ack_o    (wb_ack_o),
    .vga_hsync_o (vga_hsync_o),
    .vga_vsync_o (vga_vsync_o),
    .vga_de_o    (vga_de_o),
    .vga_pix_o   (vga_pix_o)
  );

  initial wb_clk_i = 1'b0;
  always #2 wb_clk_i = ~wb_clk_i;

  // Drawing config as the register model sees it
  function automatic draw_cfg_t model_cfg();
    draw_cfg_t cfg;
    cfg.bitmask          = shadow_regs[1];
    cfg.set_reset        = shadow_regs[2];
    cfg.enable_set_reset = shadow_regs[3][0];
    cfg.raster_op        = raster_op_e'(shadow_regs[3][2:1]);
    return cfg;
  endfunction

  // New memory word after a CPU write onto old_word
  function automatic logic [15:0] ref_mem_write(input logic [15:0] old_word,
                                                input logic [15:0] latch,
                                                input draw_cfg_t   cfg,
                                                input logic [15:0] cpu_data,
                                                input logic [1:0]  sel);
    logic [15:0] src;
    logic [15:0] res;
    logic [15:0] result;
    src = cfg.enable_set_reset ? cfg.set_reset : cpu_data;
    if (cfg.raster_op == ROP_AND) res = src & latch;
    else if (cfg.raster_op == ROP_OR) res = src | latch;
    else if (cfg.raster_op == ROP_XOR) res = src ^ latch;
    else res = src;
    result = old_word;
    for (int b = 0; b < 16; b++) begin
      if (sel[b / 8]) result[b] = cfg.bitmask[b] ? res[b] : latch[b];
    end
    return result;
  endfunction

  function automatic logic [3:0] ref_pixel(input logic [VMEM_AW-1:0] start,
                                           input int y, input int k);
    logic [VMEM_AW-1:0] addr;
    logic [15:0]        word;
    addr = start + VMEM_AW'(y * WORDS_PER_LINE + k / PIX_PER_WORD);
    word = shadow_mem[addr];
    return word[15 - 4 * (k % PIX_PER_WORD) -: 4];
  endfunction

  function automatic logic [VMEM_AW-1:0] pick_scratch();
    return scratch_q[$unsigned($random(seed)) % scratch_q.size()];
  endfunction

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      data_errors++;
    end
  endtask

  task automatic check_cfg(input string name, input draw_cfg_t exp, input draw_cfg_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected draw config %h, actual %h", name, exp, act);
      data_errors++;
    end
  endtask

  task automatic check_pix(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("Mismatch in %s: line %0d pixel %0d expected %h, actual %h",
               name, line_y, pix_k, exp, act);
      disp_errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
      disp_errors++;
    end
  endtask

  // One Wishbone access with stb held until ack
  task automatic bus_access(input logic tga, input logic we, input logic [15:0] adr,
                            input logic [15:0] dat, input logic [1:0] sel,
                            output logic [15:0] rdat);
    @(posedge wb_clk_i);
    #1;
    wb_tga_i = tga;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do begin
      @(posedge wb_clk_i);
      #1;
    end while (!wb_ack_o);
    rdat     = wb_dat_o;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic tga, input logic [15:0] adr, input logic [15:0] dat,
                          input logic [1:0] sel);
    logic [15:0] unused;
    bus_access(tga, 1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic tga, input logic [15:0] adr, output logic [15:0] dat);
    bus_access(tga, 1'b0, adr, 16'h0000, 2'b11, dat);
  endtask

  task automatic reg_write(input logic [1:0] idx, input logic [15:0] dat, input logic [1:0] sel);
    wb_write(1'b1, {14'd0, idx}, dat, sel);
    if (idx == 2'd3) begin
      if (sel[0]) shadow_regs[3] = {13'd0, dat[2:0]};
    end else begin
      if (sel[0]) shadow_regs[idx][7:0] = dat[7:0];
      if (sel[1]) shadow_regs[idx][15:8] = dat[15:8];
    end
  endtask

  task automatic reg_check(input logic [1:0] idx, input string name);
    logic [15:0] got;
    wb_read(1'b1, {14'd0, idx}, got);
    check_word(name, shadow_regs[idx], got);
  endtask

  task automatic mem_write(input logic [VMEM_AW-1:0] addr, input logic [15:0] dat,
                           input logic [1:0] sel);
    logic [15:0] next_word;
    next_word = ref_mem_write(shadow_mem[addr], shadow_latch, model_cfg(), dat, sel);
    wb_write(1'b0, 16'(addr), dat, sel);
    shadow_mem[addr] = next_word;
  endtask

  // Every CPU read also loads the latch
  task automatic mem_check(input logic [VMEM_AW-1:0] addr, input string name);
    logic [15:0] got;
    wb_read(1'b0, 16'(addr), got);
    check_word(name, shadow_mem[addr], got);
    shadow_latch = shadow_mem[addr];
  endtask

  task automatic restore_cfg();
    reg_write(2'd0, 16'h0000, 2'b11);
    reg_write(2'd1, 16'hffff, 2'b11);
    reg_write(2'd2, 16'h0000, 2'b11);
    reg_write(2'd3, 16'h0000, 2'b11);
  endtask

  task automatic test_regs();
    logic [1:0] idx;
    for (int i = 0; i < 4; i++) reg_check(2'(i), "reset values");
    check_cfg("reset values", model_cfg(), dut0.draw_cfg);
    repeat (24) begin
      idx = 2'($random(seed));
      reg_write(idx, 16'($random(seed)), 2'($random(seed)));
      reg_check(idx, "register readback");
      check_cfg("register readback", model_cfg(), dut0.draw_cfg);
    end
    restore_cfg();
  endtask

  // Scratch area 0x800..0xbff is never on screen
  task automatic test_plain_mem();
    logic [VMEM_AW-1:0] addr;
    repeat (16) begin
      addr = {2'b10, 10'($random(seed))};
      scratch_q.push_back(addr);
      mem_write(addr, 16'($random(seed)), 2'b11);
      mem_check(addr, "plain memory");
      mem_write(addr, 16'($random(seed)), 2'($random(seed)));
      mem_check(addr, "byte writes");
    end
  endtask

  task automatic test_draw_ops(input logic esr, input string name);
    logic [VMEM_AW-1:0] addr;
    for (int op = 0; op < 4; op++) begin
      reg_write(2'd3, {13'd0, 2'(op), esr}, 2'b01);
      repeat (4) begin
        reg_write(2'd1, 16'($random(seed)), 2'b11);
        reg_write(2'd2, 16'($random(seed)), 2'b11);
        mem_check(pick_scratch(), "latch load");
        addr = pick_scratch();
        mem_write(addr, 16'($random(seed)), 2'($random(seed)));
        mem_check(addr, name);
      end
    end
    restore_cfg();
  endtask

  // Fill a frame, switch start_addr during vsync, then watch two full frames
  task automatic show_frame(input logic [VMEM_AW-1:0] start);
    chk_req = 1'b0;
    for (int w = 0; w < V_ACTIVE * WORDS_PER_LINE; w++) begin
      mem_write(start + VMEM_AW'(w), 16'($random(seed)), 2'b11);
    end
    @(negedge vga_vsync_o);
    reg_write(2'd0, 16'(start), 2'b11);
    chk_req = 1'b1;
    repeat (3) @(posedge vga_vsync_o);
  endtask

  task automatic test_contention();
    logic [VMEM_AW-1:0] addr;
    repeat (40) begin
      addr = pick_scratch();
      mem_write(addr, 16'($random(seed)), 2'($random(seed)));
      mem_check(addr, "contention");
    end
    repeat (2) @(posedge vga_vsync_o);
    chk_req = 1'b0;
  endtask

  // Samples the registered display outputs at the falling edge
  always @(negedge wb_clk_i) begin
    if (!arst_n_i) begin
      pix_k      = 0;
      line_y     = 0;
      hs_low     = 0;
      vs_low     = 0;
      frame_seen = 1'b0;
      pix_on     = 1'b0;
      de_q       = 1'b0;
      hs_q       = 1'b1;
      vs_q       = 1'b1;
    end else begin
      if (!chk_req) pix_on = 1'b0;
      if (vga_de_o) begin
        if (pix_on) check_pix("display", ref_pixel(frame_start, line_y, pix_k), vga_pix_o);
        pix_k++;
      end else if (de_q) begin
        check_count("enabled cycles per line", H_ACTIVE, pix_k);
        pix_k = 0;
        line_y++;
      end
      if (!vga_hsync_o) begin
        hs_low++;
      end else if (!hs_q) begin
        check_count("hsync low cycles", H_SYNC, hs_low);
        hs_low = 0;
      end
      if (!vga_vsync_o) begin
        vs_low++;
      end else if (!vs_q) begin
        check_count("vsync low cycles", V_SYNC * H_TOTAL, vs_low);
        if (frame_seen) check_count("active lines per frame", V_ACTIVE, line_y);
        // New frame begins with the back porch
        vs_low      = 0;
        line_y      = 0;
        frame_seen  = 1'b1;
        pix_on      = chk_req;
        frame_start = shadow_regs[0][VMEM_AW-1:0];
      end
      de_q = vga_de_o;
      hs_q = vga_hsync_o;
      vs_q = vga_vsync_o;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge wb_clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Errors: %0d data, %0d display", data_errors, disp_errors);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    seed           = 32'hddab;
    data_errors    = 0;
    disp_errors    = 0;
    chk_req        = 1'b0;
    shadow_regs[0] = 16'h0000;
    shadow_regs[1] = 16'hffff;
    shadow_regs[2] = 16'h0000;
    shadow_regs[3] = 16'h0000;
    shadow_latch   = 16'h0000;
    arst_n_i       = 1'b0;
    wb_dat_i       = '0;
    wb_adr_i       = '0;
    wb_we_i        = 1'b0;
    wb_tga_i       = 1'b0;
    wb_sel_i       = 2'b00;
    wb_stb_i       = 1'b0;
    wb_cyc_i       = 1'b0;
    repeat (8) @(posedge wb_clk_i);
    #1 arst_n_i = 1'b1;

    test_regs();
    test_plain_mem();
    test_draw_ops(1'b0, "raster op");
    test_draw_ops(1'b1, "set/reset");
    show_frame(VMEM_AW'(10'($random(seed))));
    // Wraps past the end of memory
    show_frame(12'hfe0);
    test_contention();
    repeat (10) @(posedge wb_clk_i);

    $display("Errors: %0d data, %0d display", data_errors, disp_errors);
    if (data_errors + disp_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
logic/vga_pkg.sv
logic/vga_config_regs.sv
logic/cpu_mem_iface.sv
logic/scan_gen.sv
logic/mem_arbiter.sv
logic/video_ram.sv
logic/vga_core.sv
testbench/tb_vga_core.sv

// ==== Bender.yml ====
package:
  name: vga_core

sources:
  - logic/vga_pkg.sv
  - logic/vga_config_regs.sv
  - logic/cpu_mem_iface.sv
  - logic/scan_gen.sv
  - logic/mem_arbiter.sv
  - logic/video_ram.sv
  - logic/vga_core.sv
  - target: test
    files:
      - testbench/tb_vga_core.sv
